// File: sources.f
common/mips_isa_pkg.sv
common/mips_ctrl_pkg.sv
logic/main_decoder.sv
logic/alu.sv
logic/register_file.sv
fetch/pc_unit.sv
logic/mips_core.sv
bench/clock_gen.sv
bench/tb_mips_core.sv

// File: run.sh
#!/bin/sh
# build and run the MIPS core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_mips_core \
    -f sources.f -o tb_mips_core
./obj_dir/tb_mips_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
grep -q "Result: PASSED" sim.log

// File: bench/tb_mips_core.sv
// Testbench for the single-cycle MIPS core
// program ROM, data memory model, reference model, output checks and watchdog
`timescale 1ns/100ps

module tb_mips_core;

    localparam mips_isa_pkg::word_t RESET_PC = 32'h0;

    logic                    clk, rst_n, dmem_cen, dmem_wen, rf_write;
    logic [6:0]              dmem_addr;
    mips_isa_pkg::word_t     imem_addr, instr, dmem_wdata, dmem_rdata, rf_wdata;
    mips_isa_pkg::reg_addr_t rf_waddr;

    mips_isa_pkg::word_t rom [0:63];
    mips_isa_pkg::word_t dmem [0:127];
    mips_isa_pkg::word_t model_mem [0:127];
    mips_isa_pkg::word_t model_regs [0:31];
    mips_isa_pkg::word_t model_pc;
    int    seed = 66;
    int    prog_len = 0;
    int    n_checks = 0;
    int    n_errors = 0;
    int    mark_checks = 0;
    int    mark_errors = 0;
    bit    program_ready = 0;
    string sect_name [$];
    int    sect_start [$];

    clock_gen #(.PERIOD(100), .RESET_CYCLES(10)) u_clk (.clk(clk), .rst_n(rst_n));

    mips_core #(.DMEM_ADDR_W(7), .RESET_PC(RESET_PC)) DUT (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .instr(instr),
        .dmem_cen(dmem_cen), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .rf_write(rf_write),
        .rf_waddr(rf_waddr), .rf_wdata(rf_wdata)
    );

    // ROM and memory reads are combinational
    assign instr      = rom[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr];

    always @(posedge clk) begin
        if (rst_n && !dmem_cen && !dmem_wen) begin
            dmem[dmem_addr] <= dmem_wdata;
        end
    end

    // ========================================================================
    // checks and section bookkeeping
    // ========================================================================
    task automatic check_word(input string name, input mips_isa_pkg::word_t got,
                              input mips_isa_pkg::word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error: %s = 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_reg(input string name, input mips_isa_pkg::reg_addr_t got,
                             input mips_isa_pkg::reg_addr_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error: %s = 0x%02h, expected 0x%02h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic close_section(input string name);
        $display("%-14s %0d checks, %0d errors", name, n_checks - mark_checks,
                 n_errors - mark_errors);
        mark_checks = n_checks;
        mark_errors = n_errors;
    endtask

    task automatic start_section(input string name);
        sect_name.push_back(name);
        sect_start.push_back(prog_len);
    endtask

    function automatic int section_of(input int idx);
        int s;
        s = 0;
        for (int i = 0; i < sect_start.size(); i++) begin
            if (sect_start[i] <= idx) s = i;
        end
        return s;
    endfunction

    // ========================================================================
    // assembler helpers and reference model
    // ========================================================================
    function automatic mips_isa_pkg::word_t rtype_word(mips_isa_pkg::funct_t fn,
                                                       int rd, int rs, int rt);
        return {mips_isa_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic mips_isa_pkg::word_t itype_word(mips_isa_pkg::opcode_t op,
                                                       int rt, int rs, mips_isa_pkg::imm_t imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic mips_isa_pkg::word_t jtype_word(mips_isa_pkg::opcode_t op, int target);
        return {op, 26'(target)};
    endfunction

    task automatic emit(input mips_isa_pkg::word_t w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    function automatic mips_isa_pkg::imm_t rand_imm();
        mips_isa_pkg::word_t r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic mips_isa_pkg::word_t alu_ref(mips_ctrl_pkg::alu_op_t op,
                                                    mips_isa_pkg::word_t a,
                                                    mips_isa_pkg::word_t b);
        case (op)
            mips_ctrl_pkg::ALU_SUB: return a - b;
            mips_ctrl_pkg::ALU_AND: return a & b;
            mips_ctrl_pkg::ALU_OR:  return a | b;
            mips_ctrl_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:                return a + b;
        endcase
    endfunction

    // runs one instruction on the model state
    // the caller commits its writes
    function automatic void step_ref(
        input  mips_isa_pkg::word_t     pc,
        input  mips_isa_pkg::word_t     ins,
        output mips_isa_pkg::word_t     next_pc,
        output logic                    we,
        output mips_isa_pkg::reg_addr_t waddr,
        output mips_isa_pkg::word_t     wdata,
        output logic                    cen,
        output logic                    wen,
        output logic [6:0]              maddr,
        output mips_isa_pkg::word_t     mdata
    );
        mips_isa_pkg::word_t    a, b, simm, ea;
        mips_ctrl_pkg::alu_op_t op;
        a       = model_regs[ins[25:21]];
        b       = model_regs[ins[20:16]];
        simm    = {{16{ins[15]}}, ins[15:0]};
        ea      = a + simm;
        next_pc = pc + 32'd4;
        we      = 1'b0;
        waddr   = ins[20:16];
        wdata   = alu_ref(mips_ctrl_pkg::ALU_ADD, a, simm);
        cen     = 1'b1;
        wen     = 1'b1;
        maddr   = ea[8:2];
        mdata   = b;
        op      = mips_ctrl_pkg::ALU_ADD;
        case (ins[31:26])
            mips_isa_pkg::OP_RTYPE: begin
                waddr = ins[15:11];
                we    = 1'b1;
                case (ins[5:0])
                    mips_isa_pkg::FN_ADD: op = mips_ctrl_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUB: op = mips_ctrl_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND: op = mips_ctrl_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:  op = mips_ctrl_pkg::ALU_OR;
                    mips_isa_pkg::FN_SLT: op = mips_ctrl_pkg::ALU_SLT;
                    default:              we = 1'b0;
                endcase
                if (ins[5:0] == mips_isa_pkg::FN_JR) next_pc = a;
                wdata = alu_ref(op, a, b);
            end
            mips_isa_pkg::OP_ADDI: we = 1'b1;
            mips_isa_pkg::OP_LW: begin
                we    = 1'b1;
                cen   = 1'b0;
                wdata = model_mem[maddr];
            end
            mips_isa_pkg::OP_SW: begin
                cen = 1'b0;
                wen = 1'b0;
            end
            mips_isa_pkg::OP_BEQ: begin
                if (a == b) next_pc = next_pc + {simm[29:0], 2'b00};
            end
            mips_isa_pkg::OP_J: next_pc = {next_pc[31:28], ins[25:0], 2'b00};
            mips_isa_pkg::OP_JAL: begin
                we      = 1'b1;
                waddr   = mips_isa_pkg::LINK_REG;
                wdata   = pc + 32'd4;
                next_pc = {next_pc[31:28], ins[25:0], 2'b00};
            end
            default: ;
        endcase
    endfunction

    // ========================================================================
    // program
    // ========================================================================
    initial begin : assemble
        mips_isa_pkg::imm_t v;
        mips_isa_pkg::imm_t off;
        // unused words spin on themselves
        for (int i = 0; i < 64; i++) begin
            rom[i] = jtype_word(mips_isa_pkg::OP_J, i);
        end
        for (int i = 0; i < 128; i++) begin
            dmem[i]      = {16'hc3c3, 8'(i), 8'(~i)};
            model_mem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_pc = RESET_PC;

        start_section("alu");
        for (int r = 1; r <= 4; r++) begin
            v = rand_imm();
            // r1 negative and r2 positive so slt tells signed from unsigned
            if (r == 1) v[15] = 1'b1;
            if (r == 2) v[15] = 1'b0;
            emit(itype_word(mips_isa_pkg::OP_ADDI, r, 0, v));
        end
        emit(itype_word(mips_isa_pkg::OP_ADDI, 5, 1, rand_imm()));
        emit(rtype_word(mips_isa_pkg::FN_ADD, 6, 1, 2));
        emit(rtype_word(mips_isa_pkg::FN_SUB, 7, 1, 3));
        emit(rtype_word(mips_isa_pkg::FN_AND, 8, 2, 4));
        emit(rtype_word(mips_isa_pkg::FN_OR, 9, 3, 4));
        emit(rtype_word(mips_isa_pkg::FN_SLT, 10, 1, 2));
        emit(rtype_word(mips_isa_pkg::FN_SLT, 11, 2, 1));

        start_section("zero register");
        // nonzero so that a stored value would show on the reads
        emit(itype_word(mips_isa_pkg::OP_ADDI, 0, 0, rand_imm() | 16'd1));
        emit(rtype_word(mips_isa_pkg::FN_ADD, 12, 0, 0));
        emit(rtype_word(mips_isa_pkg::FN_OR, 13, 0, 5));

        start_section("load/store");
        v   = rand_imm();
        off = {7'd0, v[6:0], 2'b00};
        emit(itype_word(mips_isa_pkg::OP_SW, 6, 0, off));
        emit(itype_word(mips_isa_pkg::OP_LW, 14, 0, off));
        emit(itype_word(mips_isa_pkg::OP_SW, 7, 0, off + 16'd4));
        emit(itype_word(mips_isa_pkg::OP_LW, 15, 0, off + 16'd4));
        // untouched word shows the fill pattern
        emit(itype_word(mips_isa_pkg::OP_LW, 16, 0, off + 16'd8));

        start_section("beq");
        v = rand_imm();
        emit(itype_word(mips_isa_pkg::OP_ADDI, 17, 0, v));
        emit(itype_word(mips_isa_pkg::OP_ADDI, 18, 0, v));
        emit(itype_word(mips_isa_pkg::OP_ADDI, 19, 0, v + 16'd1));
        emit(itype_word(mips_isa_pkg::OP_BEQ, 18, 17, 16'd1));
        emit(itype_word(mips_isa_pkg::OP_ADDI, 20, 0, rand_imm()));
        emit(itype_word(mips_isa_pkg::OP_BEQ, 19, 17, 16'd1));
        emit(itype_word(mips_isa_pkg::OP_ADDI, 21, 0, rand_imm()));

        // jal lands on the subroutine and jr comes back to the j over it
        start_section("j/jal/jr");
        emit(jtype_word(mips_isa_pkg::OP_J, prog_len + 2));
        emit(itype_word(mips_isa_pkg::OP_ADDI, 22, 0, rand_imm()));
        emit(jtype_word(mips_isa_pkg::OP_JAL, prog_len + 2));
        emit(jtype_word(mips_isa_pkg::OP_J, prog_len + 3));
        emit(itype_word(mips_isa_pkg::OP_ADDI, 23, 0, rand_imm()));
        emit(rtype_word(mips_isa_pkg::FN_JR, 0, 31, 0));
        emit(rtype_word(mips_isa_pkg::FN_ADD, 24, 31, 0));
        emit(jtype_word(mips_isa_pkg::OP_J, prog_len));
        program_ready = 1'b1;
    end

    // ========================================================================
    // compare at the falling edge
    // ========================================================================
    initial begin : compare
        mips_isa_pkg::word_t     nxt, wdata, mdata, ins;
        mips_isa_pkg::reg_addr_t waddr;
        logic                    we, cen, wen;
        logic [6:0]              maddr;
        int                      idx;
        int                      cur;
        bit                      done;
        cur  = -1;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (!rst_n) begin
                check_word("imem_addr", imem_addr, RESET_PC);
            end else begin
                idx = int'(model_pc[7:2]);
                ins = rom[idx];
                if (section_of(idx) != cur) begin
                    if (cur < 0) begin
                        close_section("reset");
                    end else begin
                        close_section(sect_name[cur]);
                    end
                    cur = section_of(idx);
                end
                step_ref(model_pc, ins, nxt, we, waddr, wdata, cen, wen, maddr, mdata);
                check_word("imem_addr", imem_addr, model_pc);
                check_bit("rf_write", rf_write, we);
                if (we) begin
                    check_reg("rf_waddr", rf_waddr, waddr);
                    check_word("rf_wdata", rf_wdata, wdata);
                end
                check_bit("dmem_cen", dmem_cen, cen);
                check_bit("dmem_wen", dmem_wen, wen);
                if (!cen) begin
                    check_word("dmem_addr", {25'd0, dmem_addr}, {25'd0, maddr});
                end
                if (!wen) begin
                    check_word("dmem_wdata", dmem_wdata, mdata);
                    model_mem[maddr] = mdata;
                end
                if (we && waddr != '0) begin
                    model_regs[waddr] = wdata;
                end
                // a jump onto itself is the halt loop
                done     = (ins == jtype_word(mips_isa_pkg::OP_J, idx));
                model_pc = nxt;
            end
        end
        close_section(sect_name[cur]);
        $display("total: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // program length plus room for reset and the jal return
    initial begin : watchdog
        wait (program_ready);
        #((prog_len + 20) * 100);
        $display("timeout: the core never reached the halt loop");
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: bench/clock_gen.sv
// Testbench clock and reset source
// free-running clock, rst_n held low for a fixed number of cycles
`timescale 1ns/100ps

module clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // released on a rising edge, like any other stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: logic/mips_core.sv
// Single-cycle MIPS subset core
// ties decoder, register file, ALU and PC unit together and selects write-back
`timescale 1ns/100ps

module mips_core #(
    parameter int                  DMEM_ADDR_W = 7,
    parameter mips_isa_pkg::word_t RESET_PC    = 32'h0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output mips_isa_pkg::word_t     imem_addr,
    input  mips_isa_pkg::word_t     instr,
    output logic                    dmem_cen,
    output logic                    dmem_wen,
    output logic [DMEM_ADDR_W-1:0]  dmem_addr,
    output mips_isa_pkg::word_t     dmem_wdata,
    input  mips_isa_pkg::word_t     dmem_rdata,
    output logic                    rf_write,
    output mips_isa_pkg::reg_addr_t rf_waddr,
    output mips_isa_pkg::word_t     rf_wdata
);

    // ========================================================================
    // instruction fields
    // ========================================================================
    mips_isa_pkg::opcode_t   opcode;
    mips_isa_pkg::funct_t    funct;
    mips_isa_pkg::reg_addr_t rs, rt, rd;
    mips_isa_pkg::imm_t      imm;
    mips_isa_pkg::word_t     imm_ext;

    assign opcode  = instr[31:26];
    assign rs      = instr[25:21];
    assign rt      = instr[20:16];
    assign rd      = instr[15:11];
    assign imm     = instr[15:0];
    assign funct   = instr[5:0];
    assign imm_ext = {{16{imm[15]}}, imm};

    logic reg_dst, alu_src, mem_to_reg, reg_write, link, jump, branch, jr, zero;
    mips_ctrl_pkg::alu_mode_t alu_mode;
    mips_isa_pkg::word_t      rs_data, rt_data, alu_b, alu_result, pc, pc_plus4;

    main_decoder u_decoder (
        .opcode(opcode), .funct(funct), .reg_dst(reg_dst), .alu_src(alu_src),
        .mem_to_reg(mem_to_reg), .reg_write(reg_write), .link(link), .jump(jump),
        .branch(branch), .jr(jr), .dmem_cen(dmem_cen), .dmem_wen(dmem_wen),
        .alu_mode(alu_mode)
    );

    register_file u_regs (
        .clk(clk), .rst_n(rst_n), .we(rf_write), .rs_addr(rs), .rt_addr(rt),
        .wr_addr(rf_waddr), .wr_data(rf_wdata), .rs_data(rs_data), .rt_data(rt_data)
    );

    // immediate for lw, sw and addi
    assign alu_b = alu_src ? imm_ext : rt_data;

    alu u_alu (
        .a(rs_data), .b(alu_b), .mode(alu_mode), .funct(funct),
        .result(alu_result), .zero(zero)
    );

    pc_unit #(.RESET_PC(RESET_PC)) u_pc (
        .clk(clk), .rst_n(rst_n), .imm(imm), .index(instr[25:0]), .jump(jump),
        .branch(branch), .jr(jr), .zero(zero), .jr_target(rs_data), .pc(pc),
        .pc_plus4(pc_plus4)
    );

    // ========================================================================
    // memory port and write-back
    // ========================================================================
    assign imem_addr  = pc;
    assign dmem_addr  = alu_result[DMEM_ADDR_W+1:2];
    assign dmem_wdata = rt_data;

    assign rf_write = reg_write;
    assign rf_waddr = link ? mips_isa_pkg::LINK_REG : (reg_dst ? rd : rt);
    assign rf_wdata = link ? pc_plus4 : (mem_to_reg ? dmem_rdata : alu_result);

endmodule

// File: fetch/pc_unit.sv
// Program counter unit
// forms branch and jump targets, picks the next PC and registers it
`timescale 1ns/100ps

module pc_unit #(
    parameter mips_isa_pkg::word_t RESET_PC = 32'h0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_isa_pkg::imm_t  imm,
    input  logic [25:0]         index,
    input  logic                jump,
    input  logic                branch,
    input  logic                jr,
    input  logic                zero,
    input  mips_isa_pkg::word_t jr_target,
    output mips_isa_pkg::word_t pc,
    output mips_isa_pkg::word_t pc_plus4
);

    mips_isa_pkg::word_t    branch_target;
    mips_isa_pkg::word_t    jump_target;
    mips_isa_pkg::word_t    pc_next;
    mips_ctrl_pkg::pc_sel_t pc_sel;

    assign pc_plus4      = pc + 32'd4;
    // word offset, sign extended and scaled
    assign branch_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
    assign jump_target   = {pc_plus4[31:28], index, 2'b00};

    // jr first, then jump, then taken branch
    always_comb begin
        if (jr)                pc_sel = mips_ctrl_pkg::PC_REG;
        else if (jump)         pc_sel = mips_ctrl_pkg::PC_JUMP;
        else if (branch && zero) pc_sel = mips_ctrl_pkg::PC_BRANCH;
        else                   pc_sel = mips_ctrl_pkg::PC_SEQ;
    end

    always_comb begin
        case (pc_sel)
            mips_ctrl_pkg::PC_BRANCH: pc_next = branch_target;
            mips_ctrl_pkg::PC_JUMP:   pc_next = jump_target;
            mips_ctrl_pkg::PC_REG:    pc_next = jr_target;
            default:                  pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) pc <= RESET_PC;
        else        pc <= pc_next;
    end

    assert property (@(posedge clk) rst_n |=> (pc[1:0] == 2'b00))
        else $error("PC not word aligned");

endmodule

// File: logic/register_file.sv
// General purpose register file
// 31 writable registers, two async read ports, one sync write port, r0 tied to zero
`timescale 1ns/100ps

module register_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   we,
    input  mips_isa_pkg::reg_addr_t rs_addr,
    input  mips_isa_pkg::reg_addr_t rt_addr,
    input  mips_isa_pkg::reg_addr_t wr_addr,
    input  mips_isa_pkg::word_t    wr_data,
    output mips_isa_pkg::word_t    rs_data,
    output mips_isa_pkg::word_t    rt_data
);

    // no storage behind register 0
    mips_isa_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // combinational reads
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// File: logic/alu.sv
// Arithmetic and logic unit
// resolves the R-type funct field itself and flags a zero result
`timescale 1ns/100ps

module alu (
    input  mips_isa_pkg::word_t      a,
    input  mips_isa_pkg::word_t      b,
    input  mips_ctrl_pkg::alu_mode_t mode,
    input  mips_isa_pkg::funct_t     funct,
    output mips_isa_pkg::word_t      result,
    output logic                     zero
);

    mips_ctrl_pkg::alu_op_t op;

    // ========================================================================
    // operation select
    // ========================================================================
    always_comb begin
        op = mips_ctrl_pkg::ALU_ADD;
        case (mode)
            mips_ctrl_pkg::ALU_MODE_SUB: op = mips_ctrl_pkg::ALU_SUB;
            mips_ctrl_pkg::ALU_MODE_FUNCT: begin
                case (funct)
                    mips_isa_pkg::FN_SUB: op = mips_ctrl_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND: op = mips_ctrl_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:  op = mips_ctrl_pkg::ALU_OR;
                    mips_isa_pkg::FN_SLT: op = mips_ctrl_pkg::ALU_SLT;
                    // add, jr and anything unknown
                    default:              op = mips_ctrl_pkg::ALU_ADD;
                endcase
            end
            default: op = mips_ctrl_pkg::ALU_ADD;
        endcase
    end

    // ========================================================================
    // datapath
    // ========================================================================
    always_comb begin
        case (op)
            mips_ctrl_pkg::ALU_ADD: result = a + b;
            mips_ctrl_pkg::ALU_SUB: result = a - b;
            mips_ctrl_pkg::ALU_AND: result = a & b;
            mips_ctrl_pkg::ALU_OR:  result = a | b;
            // signed compare
            mips_ctrl_pkg::ALU_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:                result = '0;
        endcase
    end

    // beq relies on this for the equal case
    assign zero = (result == '0);

endmodule

// File: logic/main_decoder.sv
// Main decoder for the single-cycle core
// turns opcode and funct into datapath selects and memory strobes
`timescale 1ns/100ps

module main_decoder (
    input  mips_isa_pkg::opcode_t    opcode,
    input  mips_isa_pkg::funct_t     funct,
    output logic                     reg_dst,
    output logic                     alu_src,
    output logic                     mem_to_reg,
    output logic                     reg_write,
    output logic                     link,
    output logic                     jump,
    output logic                     branch,
    output logic                     jr,
    output logic                     dmem_cen,
    output logic                     dmem_wen,
    output mips_ctrl_pkg::alu_mode_t alu_mode
);

    always_comb begin
        // defaults give a no-op: nothing written, memory idle
        reg_dst    = 1'b0;
        alu_src    = 1'b0;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        link       = 1'b0;
        jump       = 1'b0;
        branch     = 1'b0;
        jr         = 1'b0;
        dmem_cen   = 1'b1;
        dmem_wen   = 1'b1;
        alu_mode   = mips_ctrl_pkg::ALU_MODE_ADD;

        case (opcode)
            mips_isa_pkg::OP_RTYPE: begin
                reg_dst  = 1'b1;
                alu_mode = mips_ctrl_pkg::ALU_MODE_FUNCT;
                case (funct)
                    mips_isa_pkg::FN_JR:  jr = 1'b1;
                    mips_isa_pkg::FN_ADD,
                    mips_isa_pkg::FN_SUB,
                    mips_isa_pkg::FN_AND,
                    mips_isa_pkg::FN_OR,
                    mips_isa_pkg::FN_SLT: reg_write = 1'b1;
                    default: ;
                endcase
            end
            mips_isa_pkg::OP_LW: begin
                alu_src    = 1'b1;
                mem_to_reg = 1'b1;
                reg_write  = 1'b1;
                dmem_cen   = 1'b0;
            end
            mips_isa_pkg::OP_SW: begin
                alu_src  = 1'b1;
                dmem_cen = 1'b0;
                dmem_wen = 1'b0;
            end
            mips_isa_pkg::OP_BEQ: begin
                branch   = 1'b1;
                alu_mode = mips_ctrl_pkg::ALU_MODE_SUB;
            end
            mips_isa_pkg::OP_J:    jump = 1'b1;
            mips_isa_pkg::OP_JAL: begin
                jump      = 1'b1;
                link      = 1'b1;
                reg_write = 1'b1;
            end
            mips_isa_pkg::OP_ADDI: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: common/mips_ctrl_pkg.sv
// MIPS core control-path package
// ALU mode and operation codes, next-PC select encoding
package mips_ctrl_pkg;

    // ========================================================================
    // ALU control
    // ========================================================================
    // decoder's coarse choice; the ALU resolves FUNCT itself
    typedef logic [1:0] alu_mode_t;

    localparam alu_mode_t ALU_MODE_ADD   = 2'd0;
    localparam alu_mode_t ALU_MODE_SUB   = 2'd1;
    localparam alu_mode_t ALU_MODE_FUNCT = 2'd2;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    // ========================================================================
    // next PC select
    // ========================================================================
    typedef logic [1:0] pc_sel_t;

    localparam pc_sel_t PC_SEQ    = 2'd0;
    localparam pc_sel_t PC_BRANCH = 2'd1;
    localparam pc_sel_t PC_JUMP   = 2'd2;
    localparam pc_sel_t PC_REG    = 2'd3;

endpackage

// File: common/mips_isa_pkg.sv
// MIPS subset instruction-set package
// machine word widths, instruction field types and opcode/funct encodings
package mips_isa_pkg;

    // ========================================================================
    // widths and field types
    // ========================================================================
    localparam int WORD_W = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [5:0]            opcode_t;
    typedef logic [5:0]            funct_t;
    typedef logic [15:0]           imm_t;

    // ========================================================================
    // opcode field, bits 31:26
    // ========================================================================
    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_J     = 6'b000010;
    localparam opcode_t OP_JAL   = 6'b000011;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_ADDI  = 6'b001000;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_SW    = 6'b101011;

    // ========================================================================
    // funct field for R-type, bits 5:0
    // ========================================================================
    localparam funct_t FN_JR  = 6'b001000;
    localparam funct_t FN_ADD = 6'b100000;
    localparam funct_t FN_SUB = 6'b100010;
    localparam funct_t FN_AND = 6'b100100;
    localparam funct_t FN_OR  = 6'b100101;
    localparam funct_t FN_SLT = 6'b101010;

    // jal return address lands here
    localparam reg_addr_t LINK_REG = 5'd31;

endpackage
